// File: Makefile
VERILATOR ?= verilator
TOP       ?= mesh_router_tb
RTL_TOP   ?= mesh_router
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= design/noc_pkg.sv design/input_port.sv design/output_port.sv design/mesh_router.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/input_port.sv
`timescale 1ns/1ps
`default_nettype none

module input_port
#(
   parameter logic [noc_pkg::coord_w-1:0] router_x   = '0,
   parameter logic [noc_pkg::coord_w-1:0] router_y   = '0,
   parameter int                          fifo_depth = 4
)
(
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           wr_valid,
   input  wire                           wr_head,
   input  wire                           wr_tail,
   input  wire  noc_pkg::flit_u          wr_data,
   input  wire  [noc_pkg::num_ports-1:0] gnt,
   output logic                          full,
   output logic [noc_pkg::num_ports-1:0] req,
   output logic                          fwd_valid,
   output logic                          fwd_head,
   output logic                          fwd_tail,
   output noc_pkg::flit_u                fwd_data
);

   localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int cnt_w = $clog2(fifo_depth + 1);

   localparam logic [ptr_w-1:0] last_ptr = ptr_w'(fifo_depth - 1);

   // Flit storage, one entry per slot
   logic [noc_pkg::flit_w-1:0] mem_data [fifo_depth];
   logic                       mem_head [fifo_depth];
   logic                       mem_tail [fifo_depth];

   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             empty;
   logic             push;
   logic             pop;

   noc_pkg::flit_u   front;
   logic             front_head;
   logic             front_tail;

   logic [noc_pkg::num_ports-1:0] head_route;
   logic [noc_pkg::num_ports-1:0] route_q;
   logic                          active;

   function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
      return (p == last_ptr) ? '0 : p + 1'b1;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Circular FIFO
   ////////////////////////////////////////////////////////////////////////////

   assign empty = (count == '0);
   assign full  = (count == cnt_w'(fifo_depth));

   // Writes while full are lost
   assign push = wr_valid && !full;
   assign pop  = (|gnt) && !empty;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= ptr_next(wr_ptr);
         if (pop)
            rd_ptr <= ptr_next(rd_ptr);
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem_data[wr_ptr] <= wr_data.data;
         mem_head[wr_ptr] <= wr_head;
         mem_tail[wr_ptr] <= wr_tail;
      end
   end

   always_comb
   begin
      front.data = mem_data[rd_ptr];
      front_head = mem_head[rd_ptr];
      front_tail = mem_tail[rd_ptr];
   end

   ////////////////////////////////////////////////////////////////////////////
   // XY routing of the head at the front
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      head_route = '0;
      if (front.head.dest_x > router_x)
         head_route[noc_pkg::port_east] = 1'b1;
      else if (front.head.dest_x < router_x)
         head_route[noc_pkg::port_west] = 1'b1;
      else if (front.head.dest_y > router_y)
         head_route[noc_pkg::port_north] = 1'b1;
      else if (front.head.dest_y < router_y)
         head_route[noc_pkg::port_south] = 1'b1;
      else
         head_route[noc_pkg::port_local] = 1'b1;
   end

   // Route is held from the head pop until the tail leaves
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         active  <= 1'b0;
         route_q <= '0;
      end
      else if (pop)
      begin
         if (front_tail)
            active <= 1'b0;
         else if (front_head && !active)
         begin
            active  <= 1'b1;
            route_q <= head_route;
         end
      end
   end

   // Drop the request while the tail goes out so the arbiter releases
   always_comb
   begin
      if (pop && front_tail)
         req = '0;
      else if (active)
         req = route_q;
      else if (!empty && front_head)
         req = head_route;
      else
         req = '0;
   end

   assign fwd_valid = pop;
   assign fwd_head  = front_head;
   assign fwd_tail  = front_tail;
   assign fwd_data  = front;

endmodule

`default_nettype wire

// File: design/mesh_router.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router
#(
   parameter logic [noc_pkg::coord_w-1:0] router_x   = 4'd2,
   parameter logic [noc_pkg::coord_w-1:0] router_y   = 4'd2,
   parameter int                          fifo_depth = 4
)
(
   input  wire                                                clk,
   input  wire                                                rst,
   input  wire  [noc_pkg::num_ports-1:0]                      in_valid,
   input  wire  [noc_pkg::num_ports-1:0]                      in_head,
   input  wire  [noc_pkg::num_ports-1:0]                      in_tail,
   input  wire  [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] in_data,
   output logic [noc_pkg::num_ports-1:0]                      in_full,
   output logic [noc_pkg::num_ports-1:0]                      out_valid,
   output logic [noc_pkg::num_ports-1:0]                      out_head,
   output logic [noc_pkg::num_ports-1:0]                      out_tail,
   output logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] out_data
);

   // req_from_in[i][o] is input i asking for output o
   logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] req_from_in;
   logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] req_to_out;
   logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] gnt_from_out;
   logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] gnt_to_in;

   logic [noc_pkg::num_ports-1:0]                 fwd_valid;
   logic [noc_pkg::num_ports-1:0]                 fwd_head;
   logic [noc_pkg::num_ports-1:0]                 fwd_tail;
   noc_pkg::flit_u [noc_pkg::num_ports-1:0]       fwd_data;

   ////////////////////////////////////////////////////////////////////////////
   // Request and grant transpose
   ////////////////////////////////////////////////////////////////////////////

   for (genvar o = 0; o < noc_pkg::num_ports; o++)
   begin : gen_xpose_o
      for (genvar i = 0; i < noc_pkg::num_ports; i++)
      begin : gen_xpose_i
         assign req_to_out[o][i] = req_from_in[i][o];
         assign gnt_to_in[i][o]  = gnt_from_out[o][i];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Ports
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < noc_pkg::num_ports; i++)
   begin : gen_in
      input_port #(.router_x(router_x), .router_y(router_y), .fifo_depth(fifo_depth)) u_in
      (
         .clk       (clk),
         .rst       (rst),
         .wr_valid  (in_valid[i]),
         .wr_head   (in_head[i]),
         .wr_tail   (in_tail[i]),
         .wr_data   (in_data[i]),
         .gnt       (gnt_to_in[i]),
         .full      (in_full[i]),
         .req       (req_from_in[i]),
         .fwd_valid (fwd_valid[i]),
         .fwd_head  (fwd_head[i]),
         .fwd_tail  (fwd_tail[i]),
         .fwd_data  (fwd_data[i])
      );
   end

   // Every output sees every input's forwarded flit
   for (genvar o = 0; o < noc_pkg::num_ports; o++)
   begin : gen_out
      output_port u_out
      (
         .clk       (clk),
         .rst       (rst),
         .req       (req_to_out[o]),
         .fwd_valid (fwd_valid),
         .fwd_head  (fwd_head),
         .fwd_tail  (fwd_tail),
         .fwd_data  (fwd_data),
         .gnt       (gnt_from_out[o]),
         .out_valid (out_valid[o]),
         .out_head  (out_head[o]),
         .out_tail  (out_tail[o]),
         .out_data  (out_data[o])
      );
   end

endmodule

`default_nettype wire

// File: design/noc_pkg.sv
`default_nettype none

package noc_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Router ports
   ////////////////////////////////////////////////////////////////////////////

   localparam int num_ports = 5;

   localparam logic [2:0] port_local = 3'd0;
   localparam logic [2:0] port_north = 3'd1;
   localparam logic [2:0] port_east  = 3'd2;
   localparam logic [2:0] port_south = 3'd3;
   localparam logic [2:0] port_west  = 3'd4;

   ////////////////////////////////////////////////////////////////////////////
   // Flit format
   ////////////////////////////////////////////////////////////////////////////

   localparam int coord_w = 4;
   localparam int flit_w  = 16;

   // Fields of a head flit
   typedef struct packed {
      logic [coord_w-1:0]          dest_x;
      logic [coord_w-1:0]          dest_y;
      logic [flit_w-2*coord_w-1:0] src_id;
   } flit_head_t;

   // Same word seen as a head or as plain body data
   typedef union packed {
      flit_head_t        head;
      logic [flit_w-1:0] data;
   } flit_u;

endpackage

`default_nettype wire

// File: design/output_port.sv
`timescale 1ns/1ps
`default_nettype none

module output_port
(
   input  wire                                          clk,
   input  wire                                          rst,
   input  wire  [noc_pkg::num_ports-1:0]                req,
   input  wire  [noc_pkg::num_ports-1:0]                fwd_valid,
   input  wire  [noc_pkg::num_ports-1:0]                fwd_head,
   input  wire  [noc_pkg::num_ports-1:0]                fwd_tail,
   input  wire  noc_pkg::flit_u [noc_pkg::num_ports-1:0] fwd_data,
   output logic [noc_pkg::num_ports-1:0]                gnt,
   output logic                                         out_valid,
   output logic                                         out_head,
   output logic                                         out_tail,
   output noc_pkg::flit_u                               out_data
);

   // One-hot state, all zero is idle
   localparam logic [noc_pkg::num_ports-1:0] st_idle = '0;

   logic [noc_pkg::num_ports-1:0] state;
   logic [noc_pkg::num_ports-1:0] next_state;

   logic           sel_valid;
   logic           sel_head;
   logic           sel_tail;
   noc_pkg::flit_u sel_data;

   ////////////////////////////////////////////////////////////////////////////
   // Fixed-priority arbiter, grant held while the request stays up
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= st_idle;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = st_idle;
      if (state == st_idle)
      begin
         // Scan downward so the lowest index wins
         for (int i = noc_pkg::num_ports - 1; i >= 0; i--)
         begin
            if (req[i])
               next_state = noc_pkg::num_ports'(1) << i;
         end
      end
      else if (|(state & req))
         next_state = state;
   end

   assign gnt = state;

   ////////////////////////////////////////////////////////////////////////////
   // Flit mux and output register
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      sel_valid = 1'b0;
      sel_head  = 1'b0;
      sel_tail  = 1'b0;
      sel_data  = '0;
      for (int i = 0; i < noc_pkg::num_ports; i++)
      begin
         if (gnt[i])
         begin
            sel_valid = fwd_valid[i];
            sel_head  = fwd_head[i];
            sel_tail  = fwd_tail[i];
            sel_data  = fwd_data[i];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out_valid <= 1'b0;
         out_head  <= 1'b0;
         out_tail  <= 1'b0;
      end
      else
      begin
         out_valid <= sel_valid;
         out_head  <= sel_head;
         out_tail  <= sel_tail;
      end
   end

   always_ff @(posedge clk)
   begin
      out_data <= sel_data;
   end

endmodule

`default_nettype wire

// File: flist.f
design/noc_pkg.sv
design/input_port.sv
design/output_port.sv
design/mesh_router.sv
sim/mesh_router_asserts.sv
sim/mesh_router_tb.sv

// File: sim/mesh_router_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router_asserts
#(
   parameter bit fifo_checks = 1'b0,
   parameter int depth       = 4
)
(
   input wire                          clk,
   input wire                          rst,
   input wire [noc_pkg::num_ports-1:0] gnt,
   input wire                          wr_valid,
   input wire                          pop,
   input wire                          full
);

   // At most one grant at a time
   a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
      else $error("Grant vector %b is not one-hot", gnt);

   // A grant moves only through idle, so packets never interleave
   a_gnt_hold: assert property (@(posedge clk) disable iff (rst)
      (gnt != '0 && $past(gnt) != '0) |-> (gnt == $past(gnt)))
      else $error("Grant switched from %b to %b without idle", $past(gnt), gnt);

   if (fifo_checks)
   begin : gen_fifo
      // Occupancy as seen from the ports
      int level;

      always_ff @(posedge clk)
      begin
         if (rst)
            level <= 0;
         else
            level <= level + int'(wr_valid && !full) - int'(pop);
      end

      a_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> (level > 0))
         else $error("Flit forwarded from an empty FIFO");

      a_full_level: assert property (@(posedge clk) disable iff (rst) full == (level == depth))
         else $error("Full flag %b with %0d flits stored", full, level);

      // Only a pop can clear full
      a_full_hold: assert property (@(posedge clk) disable iff (rst) (full && !pop) |=> full)
         else $error("Full flag fell without a pop");
   end

endmodule

`default_nettype wire

// File: sim/mesh_router_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router_tb;

   localparam int np      = noc_pkg::num_ports;
   localparam int n_pkts  = 13;
   localparam int max_len = 16;

   typedef struct packed {
      int         port;
      int         start;
      logic [3:0] dest_x;
      logic [3:0] dest_y;
      int         len;
      int         exp_out;
      logic       chk_lat;
   } pkt_t;

   typedef struct packed {
      logic        head;
      logic        tail;
      logic [15:0] data;
      logic        chk_lat;
      int          cyc;
   } exp_t;

   logic                               clk;
   logic                               rst;
   logic [np-1:0]                      in_valid;
   logic [np-1:0]                      in_head;
   logic [np-1:0]                      in_tail;
   logic [np-1:0][noc_pkg::flit_w-1:0] in_data;
   logic [np-1:0]                      in_full;
   logic [np-1:0]                      out_valid;
   logic [np-1:0]                      out_head;
   logic [np-1:0]                      out_tail;
   logic [np-1:0][noc_pkg::flit_w-1:0] out_data;

   pkt_t                       tbl [n_pkts];
   logic                       started [n_pkts];
   exp_t                       exp_q [np][$];
   int                         cur [np];
   int                         pos [np];
   logic [noc_pkg::flit_w-1:0] flits [np][max_len];
   logic                       saw_full [np];
   int                         cycle;
   int                         limit;

   mesh_router #(.router_x(4'd2), .router_y(4'd2), .fifo_depth(4)) uut
   (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_head   (in_head),
      .in_tail   (in_tail),
      .in_data   (in_data),
      .in_full   (in_full),
      .out_valid (out_valid),
      .out_head  (out_head),
      .out_tail  (out_tail),
      .out_data  (out_data)
   );

   bind output_port mesh_router_asserts u_out_asserts
      (.clk(clk), .rst(rst), .gnt(gnt), .wr_valid(1'b0), .pop(1'b0), .full(1'b0));
   bind input_port mesh_router_asserts #(.fifo_checks(1'b1), .depth(fifo_depth))
      u_in_asserts
      (.clk(clk), .rst(rst), .gnt(gnt), .wr_valid(wr_valid), .pop(fwd_valid), .full(full));

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle = cycle + 1;
      if (cycle >= limit)
      begin
         $display("Timeout after %0d cycles, output stopped arriving", cycle);
         abort_run();
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checking helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
         abort_run();
      end
   endtask

   function automatic int pending();
      int n;
      n = 0;
      for (int o = 0; o < np; o++)
         n += exp_q[o].size();
      return n;
   endfunction

   task automatic check_flit(input int o);
      exp_t e;
      assert (exp_q[o].size() > 0)
      else
      begin
         $display("Flit on output %0d at %0d ns when none was expected", o, $time);
         abort_run();
      end
      e = exp_q[o].pop_front();
      compare($sformatf("out_head[%0d]", o), 32'(e.head), 32'(out_head[o]));
      compare($sformatf("out_tail[%0d]", o), 32'(e.tail), 32'(out_tail[o]));
      compare($sformatf("out_data[%0d]", o), 32'(e.data), 32'(out_data[o]));
      if (e.chk_lat)
         compare($sformatf("out_valid[%0d] cycle", o), e.cyc, cycle);
   endtask

   // Outputs settle well before the falling edge
   always @(negedge clk)
   begin
      if (!rst)
      begin
         for (int o = 0; o < np; o++)
         begin
            if (out_valid[o])
               check_flit(o);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Packet table and injection
   ////////////////////////////////////////////////////////////////////////////

   task automatic load_table();
      // port, start, dest_x, dest_y, length, expected output, check latency
      tbl[0]  = '{0,  0, 4'd3, 4'd2,  1, 2, 1'b1};
      tbl[1]  = '{0,  4, 4'd1, 4'd2,  1, 4, 1'b1};
      tbl[2]  = '{0,  8, 4'd2, 4'd3,  1, 1, 1'b1};
      tbl[3]  = '{0, 12, 4'd2, 4'd1,  1, 3, 1'b1};
      tbl[4]  = '{0, 16, 4'd2, 4'd2,  1, 0, 1'b1};
      // X difference wins over Y
      tbl[5]  = '{0, 20, 4'd3, 4'd0,  1, 2, 1'b1};
      // Three inputs fight for the local output
      tbl[6]  = '{1, 30, 4'd2, 4'd2,  3, 0, 1'b0};
      tbl[7]  = '{2, 30, 4'd2, 4'd2,  3, 0, 1'b0};
      tbl[8]  = '{4, 30, 4'd2, 4'd2,  3, 0, 1'b0};
      // West fills its FIFO behind north
      tbl[9]  = '{1, 50, 4'd2, 4'd0,  6, 3, 1'b0};
      tbl[10] = '{4, 50, 4'd2, 4'd0, 10, 3, 1'b0};
      // Independent paths in parallel
      tbl[11] = '{0, 80, 4'd0, 4'd2,  5, 4, 1'b0};
      tbl[12] = '{2, 80, 4'd2, 4'd4,  5, 1, 1'b0};
   endtask

   task automatic start_packet(input int p, input int rel);
      noc_pkg::flit_u w;
      exp_t           e;
      int             idx;
      idx = -1;
      // Downward scan leaves the earliest due entry of this port
      for (int i = n_pkts - 1; i >= 0; i--)
      begin
         if (!started[i] && tbl[i].port == p && tbl[i].start <= rel)
            idx = i;
      end
      if (idx >= 0)
      begin
         started[idx] = 1'b1;
         cur[p] = idx;
         pos[p] = 0;
         for (int k = 0; k < tbl[idx].len; k++)
         begin
            if (k == 0)
            begin
               w.head.dest_x = tbl[idx].dest_x;
               w.head.dest_y = tbl[idx].dest_y;
               w.head.src_id = {4'(p), 4'(idx)};
            end
            else
               w.data = 16'($urandom);
            flits[p][k] = w.data;
            e.head    = (k == 0);
            e.tail    = (k == tbl[idx].len - 1);
            e.data    = w.data;
            e.chk_lat = tbl[idx].chk_lat && (k == 0);
            // Written at the next edge, registered out two edges later
            e.cyc     = cycle + 3;
            exp_q[tbl[idx].exp_out].push_back(e);
         end
      end
   endtask

   task automatic drive_step(input int rel, output bit busy);
      busy     = 1'b0;
      in_valid = '0;
      in_head  = '0;
      in_tail  = '0;
      for (int p = 0; p < np; p++)
      begin
         if (in_full[p])
            saw_full[p] = 1'b1;
         if (cur[p] < 0)
            start_packet(p, rel);
         if (cur[p] >= 0 && !in_full[p])
         begin
            in_valid[p] = 1'b1;
            in_head[p]  = (pos[p] == 0);
            in_tail[p]  = (pos[p] == tbl[cur[p]].len - 1);
            in_data[p]  = flits[p][pos[p]];
            pos[p]++;
            if (pos[p] == tbl[cur[p]].len)
               cur[p] = -1;
         end
         if (cur[p] >= 0)
            busy = 1'b1;
      end
      for (int i = 0; i < n_pkts; i++)
      begin
         if (!started[i])
            busy = 1'b1;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin : main
      int base;
      bit busy;
      void'($urandom(58));
      cycle    = 0;
      rst      = 1'b1;
      in_valid = '0;
      in_head  = '0;
      in_tail  = '0;
      in_data  = '0;
      load_table();
      limit = 200;
      for (int i = 0; i < n_pkts; i++)
         limit += tbl[i].len * 5;
      for (int p = 0; p < np; p++)
      begin
         cur[p]      = -1;
         pos[p]      = 0;
         saw_full[p] = 1'b0;
      end
      for (int i = 0; i < n_pkts; i++)
         started[i] = 1'b0;

      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;

      // Idle router stays quiet
      repeat (4)
      begin
         @(posedge clk);
         #1;
         compare("out_valid", 32'(0), 32'(out_valid));
         compare("in_full", 32'(0), 32'(in_full));
      end

      base = cycle;
      busy = 1'b1;
      while (busy)
      begin
         drive_step(cycle - base, busy);
         @(posedge clk);
         #1;
      end
      in_valid = '0;
      in_head  = '0;
      in_tail  = '0;

      while (pending() > 0)
         @(posedge clk);
      @(posedge clk);
      #1;
      compare("in_full", 32'(0), 32'(in_full));
      compare("saw in_full[4]", 32'(1), 32'(saw_full[4]));
      compare("out_valid", 32'(0), 32'(out_valid));
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire
